/* ncpu64k_pkg.sv */
package ncpu64k_pkg;

   // Slots retired per cycle
   localparam int CW          = 2;

   // Word-aligned PC, register address and data widths
   localparam int PC_W        = 30;
   localparam int LRF_AW      = 5;
   localparam int DW          = 32;

   localparam int NUM_LRF     = 1 << LRF_AW;

   // Interrupt controller lines
   localparam int NUM_IRQ     = 8;

   // Commit trace FIFO
   localparam int TRACE_DEPTH = 16;
   localparam int TRACE_AW    = $clog2(TRACE_DEPTH);

   // One retired slot as seen by the co-simulation checker
   typedef struct packed
   {
      logic                slot;
      logic [PC_W-1:0]     pc;
      logic [LRF_AW-1:0]   rd;
      logic                we;
      logic [DW-1:0]       dat;
      logic                exc;
      logic [NUM_IRQ-1:0]  irr;
   } trace_rec_t;

endpackage

/* ncpu64k_cmt_if.sv */
`timescale 1ns/1ps

interface ncpu64k_cmt_if;

   logic [ncpu64k_pkg::CW-1:0]                          fire;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]        pc;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]      lrd;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]          lrd_dat;
   logic [ncpu64k_pkg::CW-1:0]                          lrd_we;
   logic                                                exc;
   logic [ncpu64k_pkg::DW-1:0]                          exc_vect;
   // Retire stage pipeline enable
   logic                                                p_ce_s1;

   modport drv
   (
      output fire, pc, lrd, lrd_dat, lrd_we, exc, exc_vect, p_ce_s1
   );

   modport rf
   (
      input  fire, lrd, lrd_dat, lrd_we
   );

   modport mon
   (
      input  fire, pc, lrd, lrd_dat, lrd_we, exc, exc_vect, p_ce_s1
   );

endinterface

/* cmt_retire.sv */
`timescale 1ns/1ps

module cmt_retire
(
   input  logic                                               clk,
   input  logic                                               arst_n,
   input  logic                                               stall,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_valid,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]       in_pc,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]     in_rd,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_rd_we,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         in_dat,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_exc,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         in_exc_vect,
   ncpu64k_cmt_if.drv                                         cmt
);

   logic                                               p_ce;
   logic [ncpu64k_pkg::CW-1:0]                         s1_valid;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]       s1_pc;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]     s1_rd;
   logic [ncpu64k_pkg::CW-1:0]                         s1_rd_we;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         s1_dat;
   logic [ncpu64k_pkg::CW-1:0]                         s1_exc;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         s1_exc_vect;
   logic [ncpu64k_pkg::CW-1:0]                         fire_c;
   logic [ncpu64k_pkg::CW-1:0]                         we_c;
   logic                                               older_exc;
   logic [ncpu64k_pkg::DW-1:0]                         vect_c;

   assign p_ce = ~stall;

   // A stalled edge retires nothing on the next cycle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         s1_valid <= '0;
      end
      else
      begin
         s1_valid <= p_ce ? in_valid : '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         s1_pc       <= in_pc;
         s1_rd       <= in_rd;
         s1_rd_we    <= in_rd_we;
         s1_dat      <= in_dat;
         s1_exc      <= in_exc;
         s1_exc_vect <= in_exc_vect;
      end
   end

   // In-order cancel, slot 0 is the oldest
   always_comb
   begin
      older_exc = 1'b0;
      vect_c    = '0;
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         fire_c[i] = s1_valid[i] & ~older_exc;
         // Excepting slot retires without a write
         we_c[i]   = fire_c[i] & s1_rd_we[i] & ~s1_exc[i];
         if (fire_c[i] && s1_exc[i])
         begin
            vect_c = s1_exc_vect[i*ncpu64k_pkg::DW +: ncpu64k_pkg::DW];
         end
         older_exc = older_exc | (s1_valid[i] & s1_exc[i]);
      end
   end

   assign cmt.fire     = fire_c;
   assign cmt.pc       = s1_pc;
   assign cmt.lrd      = s1_rd;
   assign cmt.lrd_dat  = s1_dat;
   assign cmt.lrd_we   = we_c;
   assign cmt.exc      = older_exc;
   assign cmt.exc_vect = vect_c;
   assign cmt.p_ce_s1  = p_ce;

endmodule

/* arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile
(
   input  logic                               clk,
   input  logic                               arst_n,
   ncpu64k_cmt_if.rf                          cmt,
   input  logic [ncpu64k_pkg::LRF_AW-1:0]     raddr,
   output logic [ncpu64k_pkg::DW-1:0]         rdata
);

   logic [ncpu64k_pkg::DW-1:0] regs [ncpu64k_pkg::NUM_LRF];

   // Later slots overwrite earlier ones on the same register
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int r = 0; r < ncpu64k_pkg::NUM_LRF; r++)
         begin
            regs[r] <= '0;
         end
      end
      else
      begin
         for (int s = 0; s < ncpu64k_pkg::CW; s++)
         begin
            if (cmt.fire[s] && cmt.lrd_we[s] &&
                (cmt.lrd[s*ncpu64k_pkg::LRF_AW +: ncpu64k_pkg::LRF_AW] != '0))
            begin
               regs[cmt.lrd[s*ncpu64k_pkg::LRF_AW +: ncpu64k_pkg::LRF_AW]] <=
                  cmt.lrd_dat[s*ncpu64k_pkg::DW +: ncpu64k_pkg::DW];
            end
         end
      end
   end

   // r0 is hard-wired to zero
   assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

/* difftest_commit_inst.sv */
`timescale 1ns/1ps

module difftest_commit_inst
(
   input  logic                                               clk,
   input  logic                                               arst_n,
   input  logic [ncpu64k_pkg::CW-1:0]                         valid,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]       pc,
   input  logic [ncpu64k_pkg::CW-1:0]                         wen,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]     wnum,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         wdata,
   input  logic [ncpu64k_pkg::CW-1:0]                         excp,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::NUM_IRQ-1:0]    irqc_irr,
   input  logic                                               trace_pop,
   output logic                                               trace_empty,
   output ncpu64k_pkg::trace_rec_t                            trace_head,
   output logic                                               trace_overflow
);

   ncpu64k_pkg::trace_rec_t                  mem [ncpu64k_pkg::TRACE_DEPTH];
   ncpu64k_pkg::trace_rec_t                  rec [ncpu64k_pkg::CW];
   logic [ncpu64k_pkg::TRACE_AW-1:0]         wr_addr [ncpu64k_pkg::CW];
   logic [ncpu64k_pkg::TRACE_AW-1:0]         wptr_q;
   logic [ncpu64k_pkg::TRACE_AW-1:0]         rptr_q;
   logic [ncpu64k_pkg::TRACE_AW:0]           cnt_q;
   logic [ncpu64k_pkg::TRACE_AW:0]           cnt_pop;
   logic [ncpu64k_pkg::TRACE_AW:0]           cnt_nxt;
   logic [ncpu64k_pkg::TRACE_AW:0]           push_n;
   logic [ncpu64k_pkg::TRACE_AW:0]           push_eff;
   logic                                     empty_q;
   logic                                     ovf_q;
   logic                                     pop;
   logic                                     fits;

   always_comb
   begin
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         rec[i].slot = 1'(i);
         rec[i].pc   = pc[i*ncpu64k_pkg::PC_W +: ncpu64k_pkg::PC_W];
         rec[i].rd   = wnum[i*ncpu64k_pkg::LRF_AW +: ncpu64k_pkg::LRF_AW];
         rec[i].we   = wen[i];
         rec[i].dat  = wdata[i*ncpu64k_pkg::DW +: ncpu64k_pkg::DW];
         rec[i].exc  = excp[i];
         rec[i].irr  = irqc_irr[i*ncpu64k_pkg::NUM_IRQ +: ncpu64k_pkg::NUM_IRQ];
      end
   end

   // Valid slots pack into consecutive entries, slot 0 first
   always_comb
   begin
      push_n = '0;
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         wr_addr[i] = wptr_q + push_n[ncpu64k_pkg::TRACE_AW-1:0];
         push_n     = push_n + {{ncpu64k_pkg::TRACE_AW{1'b0}}, valid[i]};
      end
   end

   assign pop      = trace_pop & ~empty_q;
   assign cnt_pop  = cnt_q - {{ncpu64k_pkg::TRACE_AW{1'b0}}, pop};
   // All or nothing for one cycle's records
   assign fits     = (cnt_pop + push_n) <= ncpu64k_pkg::TRACE_DEPTH;
   assign push_eff = fits ? push_n : '0;
   assign cnt_nxt  = cnt_pop + push_eff;

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         if (valid[i] && fits)
         begin
            mem[wr_addr[i]] <= rec[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         cnt_q   <= '0;
         empty_q <= 1'b1;
         ovf_q   <= 1'b0;
      end
      else
      begin
         wptr_q  <= wptr_q + push_eff[ncpu64k_pkg::TRACE_AW-1:0];
         rptr_q  <= rptr_q + {{(ncpu64k_pkg::TRACE_AW-1){1'b0}}, pop};
         cnt_q   <= cnt_nxt;
         empty_q <= (cnt_nxt == '0);
         // Sticky until reset
         ovf_q   <= ovf_q | ((push_n != '0) & ~fits);
      end
   end

   assign trace_empty    = empty_q;
   assign trace_head     = mem[rptr_q];
   assign trace_overflow = ovf_q;

endmodule

/* difftest.sv */
`timescale 1ns/1ps

module difftest
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   ncpu64k_cmt_if.mon                           cmt,
   input  logic [ncpu64k_pkg::NUM_IRQ-1:0]      msr_irqc_irr,
   input  logic                                 trace_pop,
   output logic                                 trace_empty,
   output ncpu64k_pkg::trace_rec_t              trace_head,
   output logic                                 trace_overflow
);

   logic [ncpu64k_pkg::NUM_IRQ-1:0]                    s1o_msr_irqc_irr;
   logic [ncpu64k_pkg::CW-1:0]                         commit_valid_ff;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]       commit_pc_ff;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]     commit_rf_waddr_ff;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         commit_rf_wdat_ff;
   logic [ncpu64k_pkg::CW-1:0]                         commit_rf_we_ff;
   logic                                               commit_excp_ff;
   logic [ncpu64k_pkg::NUM_IRQ-1:0]                    commit_irqc_irr_ff;
   logic [ncpu64k_pkg::CW-1:0]                         excp_slot;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::NUM_IRQ-1:0]    irr_slot;
   logic                                               younger_fire;

   // Pending interrupts follow the retire stage enable
   always_ff @(posedge clk)
   begin
      if (cmt.p_ce_s1)
      begin
         s1o_msr_irqc_irr <= msr_irqc_irr;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         commit_valid_ff <= '0;
         commit_rf_we_ff <= '0;
      end
      else
      begin
         commit_valid_ff <= cmt.fire;
         commit_rf_we_ff <= cmt.lrd_we;
      end
   end

   always_ff @(posedge clk)
   begin
      commit_pc_ff       <= cmt.pc;
      commit_rf_waddr_ff <= cmt.lrd;
      commit_rf_wdat_ff  <= cmt.lrd_dat;
      commit_excp_ff     <= cmt.exc;
      commit_irqc_irr_ff <= s1o_msr_irqc_irr;
   end

   // The youngest firing slot carries the exception
   always_comb
   begin
      younger_fire = 1'b0;
      for (int i = ncpu64k_pkg::CW-1; i >= 0; i--)
      begin
         excp_slot[i] = commit_excp_ff & commit_valid_ff[i] & ~younger_fire;
         irr_slot[i*ncpu64k_pkg::NUM_IRQ +: ncpu64k_pkg::NUM_IRQ] =
            excp_slot[i] ? commit_irqc_irr_ff : '0;
         younger_fire = younger_fire | commit_valid_ff[i];
      end
   end

   difftest_commit_inst u_difftest_commit_inst
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .valid          (commit_valid_ff),
      .pc             (commit_pc_ff),
      .wen            (commit_rf_we_ff),
      .wnum           (commit_rf_waddr_ff),
      .wdata          (commit_rf_wdat_ff),
      .excp           (excp_slot),
      .irqc_irr       (irr_slot),
      .trace_pop      (trace_pop),
      .trace_empty    (trace_empty),
      .trace_head     (trace_head),
      .trace_overflow (trace_overflow)
   );

endmodule

/* ncpu64k_cmt_top.sv */
`timescale 1ns/1ps

module ncpu64k_cmt_top
(
   input  logic                                               clk,
   input  logic                                               arst_n,
   input  logic                                               stall,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_valid,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PC_W-1:0]       in_pc,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::LRF_AW-1:0]     in_rd,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_rd_we,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         in_dat,
   input  logic [ncpu64k_pkg::CW-1:0]                         in_exc,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         in_exc_vect,
   input  logic [ncpu64k_pkg::NUM_IRQ-1:0]                    msr_irqc_irr,
   input  logic [ncpu64k_pkg::LRF_AW-1:0]                     rf_raddr,
   output logic [ncpu64k_pkg::DW-1:0]                         rf_rdata,
   input  logic                                               trace_pop,
   output logic                                               trace_empty,
   output logic                                               trace_overflow,
   output logic                                               trace_slot,
   output logic [ncpu64k_pkg::PC_W-1:0]                       trace_pc,
   output logic [ncpu64k_pkg::LRF_AW-1:0]                     trace_rd,
   output logic                                               trace_we,
   output logic [ncpu64k_pkg::DW-1:0]                         trace_dat,
   output logic                                               trace_exc,
   output logic [ncpu64k_pkg::NUM_IRQ-1:0]                    trace_irr
);

   ncpu64k_pkg::trace_rec_t trace_head;

   ncpu64k_cmt_if cmt_bus ();

   cmt_retire u_cmt_retire
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .stall       (stall),
      .in_valid    (in_valid),
      .in_pc       (in_pc),
      .in_rd       (in_rd),
      .in_rd_we    (in_rd_we),
      .in_dat      (in_dat),
      .in_exc      (in_exc),
      .in_exc_vect (in_exc_vect),
      .cmt         (cmt_bus.drv)
   );

   arch_regfile u_arch_regfile
   (
      .clk    (clk),
      .arst_n (arst_n),
      .cmt    (cmt_bus.rf),
      .raddr  (rf_raddr),
      .rdata  (rf_rdata)
   );

   difftest u_difftest
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .cmt            (cmt_bus.mon),
      .msr_irqc_irr   (msr_irqc_irr),
      .trace_pop      (trace_pop),
      .trace_empty    (trace_empty),
      .trace_head     (trace_head),
      .trace_overflow (trace_overflow)
   );

   // Head record fields for the checker
   assign trace_slot = trace_head.slot;
   assign trace_pc   = trace_head.pc;
   assign trace_rd   = trace_head.rd;
   assign trace_we   = trace_head.we;
   assign trace_dat  = trace_head.dat;
   assign trace_exc  = trace_head.exc;
   assign trace_irr  = trace_head.irr;

endmodule

/* tb_ncpu64k_cmt_assertions.sv */
`timescale 1ns/1ps

module tb_ncpu64k_cmt_assertions
(
   input logic                                clk,
   input logic                                arst_n,
   input logic                                stall,
   input logic [ncpu64k_pkg::CW-1:0]          in_valid,
   input logic                                trace_pop,
   input logic                                trace_empty,
   input logic                                trace_overflow,
   input logic [ncpu64k_pkg::PC_W-1:0]        trace_pc,
   input logic [ncpu64k_pkg::LRF_AW-1:0]      trace_rd,
   input logic [ncpu64k_pkg::DW-1:0]          trace_dat
);

   a_reset_state: assert property (@(posedge clk)
      $rose(arst_n) |-> trace_empty && !trace_overflow)
      else $error("trace FIFO not empty or overflow set after reset");

   a_ovf_sticky: assert property (@(posedge clk) disable iff (!arst_n)
      !$fell(trace_overflow))
      else $error("trace_overflow cleared without reset");

   // Records are pushed two edges after an unstalled valid input
   a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      trace_pop && trace_empty && !$past(!stall && (in_valid != '0), 2) |=>
      trace_empty &&
      ({trace_pc, trace_rd, trace_dat} === $past({trace_pc, trace_rd, trace_dat})))
      else $error("head changed on a pop of an empty FIFO");

endmodule

bind ncpu64k_cmt_top tb_ncpu64k_cmt_assertions u_assertions (.*);

/* tb_ncpu64k_cmt.sv */
`timescale 1ns/1ps

module tb_ncpu64k_cmt;

   logic                                          clk = 1'b0;
   logic                                          arst_n;
   logic                                          stall;
   logic                                          trace_pop;
   logic [ncpu64k_pkg::CW-1:0]                    in_valid;
   logic [ncpu64k_pkg::CW-1:0]                    in_exc;
   logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]    in_exc_vect;
   logic [ncpu64k_pkg::NUM_IRQ-1:0]               irq;
   logic [ncpu64k_pkg::LRF_AW-1:0]                rf_raddr;
   logic [ncpu64k_pkg::DW-1:0]                    rf_rdata;
   logic                                          trace_empty;
   logic                                          trace_overflow;
   ncpu64k_pkg::trace_rec_t                       st [ncpu64k_pkg::CW];
   ncpu64k_pkg::trace_rec_t                       head;

   // Reference model state
   ncpu64k_pkg::trace_rec_t                       s1_st [ncpu64k_pkg::CW];
   ncpu64k_pkg::trace_rec_t                       dt_rec [ncpu64k_pkg::CW];
   ncpu64k_pkg::trace_rec_t                       fifo [$];
   logic [ncpu64k_pkg::CW-1:0]                    s1_v = '0;
   logic [ncpu64k_pkg::CW-1:0]                    s1_exc = '0;
   logic [ncpu64k_pkg::CW-1:0]                    dt_fire = '0;
   logic [ncpu64k_pkg::NUM_IRQ-1:0]               irq_m = '0;
   logic [ncpu64k_pkg::DW-1:0]                    regs_m [32];
   logic                                          ovf_m = 1'b0;

   int cycles = 0;
   int limit = 1000000;
   int checks = 0;
   int errors = 0;
   int test_err = 0;
   int tests = 0;
   int tests_failed = 0;
   int cur_test = 0;

   always #2 clk = ~clk;

   ncpu64k_cmt_top DUT
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .stall          (stall),
      .in_valid       (in_valid),
      .in_pc          ({st[1].pc, st[0].pc}),
      .in_rd          ({st[1].rd, st[0].rd}),
      .in_rd_we       ({st[1].we, st[0].we}),
      .in_dat         ({st[1].dat, st[0].dat}),
      .in_exc         (in_exc),
      .in_exc_vect    (in_exc_vect),
      .msr_irqc_irr   (irq),
      .rf_raddr       (rf_raddr),
      .rf_rdata       (rf_rdata),
      .trace_pop      (trace_pop),
      .trace_empty    (trace_empty),
      .trace_overflow (trace_overflow),
      .trace_slot     (head.slot),
      .trace_pc       (head.pc),
      .trace_rd       (head.rd),
      .trace_we       (head.we),
      .trace_dat      (head.dat),
      .trace_exc      (head.exc),
      .trace_irr      (head.irr)
   );

   initial
   begin
      while (cycles <= limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Run stopped: no progress within %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         test_err++;
         $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // One clock edge of the retire pipe, FIFO and register file
   task automatic model_edge();
      ncpu64k_pkg::trace_rec_t r;
      int n;
      logic older;
      n = int'(dt_fire[0]) + int'(dt_fire[1]);
      if (trace_pop && fifo.size() > 0)
         void'(fifo.pop_front());
      if (fifo.size() + n <= ncpu64k_pkg::TRACE_DEPTH)
      begin
         for (int i = 0; i < ncpu64k_pkg::CW; i++)
            if (dt_fire[i])
               fifo.push_back(dt_rec[i]);
      end
      else
         ovf_m = 1'b1;
      older = 1'b0;
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         r          = s1_st[i];
         dt_fire[i] = s1_v[i] & ~older;
         r.slot     = 1'(i);
         r.exc      = dt_fire[i] & s1_exc[i];
         r.we       = dt_fire[i] & s1_st[i].we & ~s1_exc[i];
         r.irr      = r.exc ? irq_m : '0;
         dt_rec[i]  = r;
         if (r.we && r.rd != '0)
            regs_m[r.rd] = r.dat;
         older = older | (s1_v[i] & s1_exc[i]);
      end
      if (!stall)
      begin
         s1_st  = st;
         s1_v   = in_valid;
         s1_exc = in_exc;
         irq_m  = irq;
      end
      else
         s1_v = '0;
   endtask

   task automatic step();
      @(posedge clk);
      model_edge();
      #1;
      check("trace_empty", trace_empty, fifo.size() == 0);
      check("trace_overflow", trace_overflow, ovf_m);
      if (fifo.size() > 0)
         check("trace_head", head, fifo[0]);
   endtask

   task automatic end_test();
      if (cur_test != 0)
      begin
         tests++;
         if (test_err != 0)
            tests_failed++;
         $display("test %0d finished with %0d errors", cur_test, test_err);
      end
      test_err = 0;
   endtask

   initial
   begin
      int fd;
      int total_cycles;
      string line;
      logic [31:0] f [14];
      void'($urandom(86604));
      arst_n = 1'b0;
      stall = 1'b0;
      trace_pop = 1'b0;
      in_valid = '0;
      in_exc = '0;
      in_exc_vect = '0;
      irq = '0;
      rf_raddr = '0;
      for (int i = 0; i < ncpu64k_pkg::CW; i++)
      begin
         st[i] = '0;
         s1_st[i] = '0;
         dt_rec[i] = '0;
      end
      for (int r = 0; r < 32; r++)
         regs_m[r] = '0;
      fd = $fopen("ncpu64k_cmt_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the pattern file");
         $display("TEST RESULT: FAIL");
         $finish;
      end
      else
      begin
         // First pass sizes the timeout
         total_cycles = 0;
         while ($fgets(line, fd))
            if ($sscanf(line, "C %d", f[0]) == 1)
               total_cycles = total_cycles + f[0];
         limit = 4 * total_cycles + 50;
         $fclose(fd);
         fd = $fopen("ncpu64k_cmt_patterns.txt", "r");
         repeat (2) @(posedge clk);
         #1 arst_n = 1'b1;
         while ($fgets(line, fd))
         begin
            if ($sscanf(line, "T %d", f[0]) == 1)
            begin
               end_test();
               cur_test = f[0];
            end
            else if ($sscanf(line, "E %h %h", f[0], f[1]) == 2)
            begin
               rf_raddr = f[0];
               #0.1;
               check("rf_rdata", rf_rdata, f[1]);
               check("reference register", regs_m[f[0]], f[1]);
            end
            else if ($sscanf(line, "O %h", f[0]) == 1)
               check("trace_overflow", trace_overflow, f[0]);
            else if ($sscanf(line, "C %d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                             f[9], f[10], f[11], f[12], f[13]) == 14)
            begin
               repeat (f[0])
               begin
                  stall = f[1];
                  trace_pop = f[2];
                  irq = f[3];
                  for (int i = 0; i < ncpu64k_pkg::CW; i++)
                  begin
                     in_valid[i] = f[4+5*i];
                     st[i].we    = f[5+5*i];
                     st[i].rd    = f[6+5*i];
                     st[i].dat   = f[7+5*i];
                     in_exc[i]   = f[8+5*i];
                     st[i].pc    = $urandom;
                  end
                  in_exc_vect = {$urandom, $urandom};
                  step();
               end
            end
         end
         end_test();
         $fclose(fd);
         $display("%0d tests, %0d failed, %0d checks, %0d errors",
                  tests, tests_failed, checks, errors);
         if (errors == 0 && tests > 0)
            $display("TEST RESULT: PASS");
         else
            $display("TEST RESULT: FAIL");
         $finish;
      end
   end

endmodule

/* ncpu64k_cmt_patterns.txt */
# C count stall pop irq v0 we0 rd0 dat0 exc0 v1 we1 rd1 dat1 exc1 (count decimal, rest hex)
# E reg value checks a register, O value checks trace_overflow, T num starts a test
T 1
C 1 0 0 00 1 1 01 11111111 0 1 1 02 22222222 0
C 5 0 1 00 0 0 00 00000000 0 0 0 00 00000000 0
E 01 11111111
E 02 22222222
T 2
C 1 0 0 00 1 1 03 aaaa0001 0 1 1 03 bbbb0002 0
C 5 0 1 00 0 0 00 00000000 0 0 0 00 00000000 0
E 03 bbbb0002
T 3
C 1 0 0 5a 1 1 04 0000cccc 1 1 1 05 0000dddd 0
C 5 0 1 a5 0 0 00 00000000 0 0 0 00 00000000 0
E 04 00000000
E 05 00000000
C 1 0 0 33 1 1 06 12345678 0 1 1 07 87654321 1
C 5 0 1 00 0 0 00 00000000 0 0 0 00 00000000 0
E 06 12345678
E 07 00000000
T 4
C 1 1 0 ff 1 1 08 deadbeef 0 1 1 09 cafef00d 0
C 1 1 0 ee 1 1 08 deadbeef 0 1 1 09 cafef00d 1
C 1 0 0 21 0 0 00 00000000 0 0 0 00 00000000 0
C 1 0 0 21 1 0 0c 00000000 1 0 0 00 00000000 0
C 5 0 1 21 0 0 00 00000000 0 0 0 00 00000000 0
E 08 00000000
E 09 00000000
T 5
C 10 0 0 00 1 1 0a 00000a0a 0 1 1 0b 00000b0b 0
C 3 0 0 00 0 0 00 00000000 0 0 0 00 00000000 0
O 1
C 20 0 1 00 0 0 00 00000000 0 0 0 00 00000000 0
E 0a 00000a0a
T 6
C 1 0 0 00 1 1 00 ffffffff 0 0 0 00 00000000 0
C 5 0 1 00 0 0 00 00000000 0 0 0 00 00000000 0
E 00 00000000

/* ncpu64k_cmt.f */
ncpu64k_pkg.sv
ncpu64k_cmt_if.sv
cmt_retire.sv
arch_regfile.sv
difftest_commit_inst.sv
difftest.sv
ncpu64k_cmt_top.sv
tb_ncpu64k_cmt_assertions.sv
tb_ncpu64k_cmt.sv

/* Bender.yml */
package:
  name: ncpu64k_cmt

sources:
  - ncpu64k_pkg.sv
  - ncpu64k_cmt_if.sv
  - cmt_retire.sv
  - arch_regfile.sv
  - difftest_commit_inst.sv
  - difftest.sv
  - ncpu64k_cmt_top.sv
  - target: test
    files:
      - tb_ncpu64k_cmt_assertions.sv
      - tb_ncpu64k_cmt.sv
